//--- Bender.yml
package:
  name: mips_core

sources:
  - files:
      - mips_pkg.sv
      - mips_alu.sv
      - mips_regfile.sv
      - mips_branch_cmp.sv
      - mips_load_store_align.sv
      - mips_perf_counters.sv
      - mips_control.sv
      - mips_datapath.sv
      - mips_core.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_mips_core.sv

//--- mips_alu.sv
`default_nettype none

module mips_alu (
   input  mips_pkg::word_t   a,
   input  mips_pkg::word_t   b,
   input  mips_pkg::alu_op_t op,
   output mips_pkg::word_t   result
);
   import mips_pkg::*;

   shamt_t sh;

   assign sh = a[4:0];   // shift amount from low bits of a

   always_comb begin
      case (op)
         ALU_ADD:  result = a + b;
         ALU_SUB:  result = a - b;
         ALU_AND:  result = a & b;
         ALU_OR:   result = a | b;
         ALU_XOR:  result = a ^ b;
         ALU_NOR:  result = ~(a | b);
         ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
         ALU_SLTU: result = {31'b0, a < b};
         ALU_SLL:  result = b << sh;
         ALU_SRL:  result = b >> sh;
         ALU_SRA:  result = word_t'($signed(b) >>> sh);
         ALU_LUI:  result = {b[15:0], 16'h0000};
         default:  result = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- mips_branch_cmp.sv
`default_nettype none

module mips_branch_cmp (
   input  mips_pkg::opcode_t   opcode,
   input  mips_pkg::reg_addr_t rt,
   input  mips_pkg::word_t     a,
   input  mips_pkg::word_t     b,
   output logic                taken
);
   import mips_pkg::*;

   logic a_neg;
   logic a_zero;

   assign a_neg  = a[31];
   assign a_zero = (a == '0);

   always_comb begin
      case (opcode)
         OP_BEQ:    taken = (a == b);
         OP_BNE:    taken = (a != b);
         OP_BLEZ:   taken = a_neg | a_zero;
         OP_BGTZ:   taken = ~a_neg & ~a_zero;
         OP_REGIMM: begin
            if (rt == 5'd1) begin
               taken = ~a_neg;   // bgez
            end else begin
               taken = (rt == 5'd0) & a_neg;   // bltz
            end
         end
         default:   taken = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

//--- mips_control.sv
`default_nettype none

module mips_control (
   input  mips_pkg::word_t    ex_instr,
   input  mips_pkg::word_t    mw_instr,
   output mips_pkg::ex_ctrl_t ex_ctrl
);
   import mips_pkg::*;

   ex_ctrl_t  mw_ctrl;
   reg_addr_t mw_dest;
   logic      mw_fwd;

   function automatic ex_ctrl_t decode(input word_t instr);
      ex_ctrl_t c;
      opcode_t  op;
      funct_t   fn;
      op = instr[31:26];
      fn = instr[5:0];
      c.alu_op       = ALU_ADD;
      c.src_a        = SRCA_RS;
      c.src_b        = SRCB_RT;
      c.reg_dst      = DST_RT;
      c.wb_sel       = WB_ALU;
      c.pc_src       = PC_PLUS4;
      c.reg_write    = 1'b0;
      c.mem_read     = 1'b0;
      c.mem_write    = 1'b0;
      c.mem_size     = SIZE_WORD;
      c.load_signed  = 1'b1;
      c.imm_zero_ext = 1'b0;
      case (op)
         OP_RTYPE: begin
            c.reg_dst   = DST_RD;
            c.reg_write = 1'b1;
            case (fn)
               FN_SLL:  begin c.alu_op = ALU_SLL; c.src_a = SRCA_SHAMT; end
               FN_SRL:  begin c.alu_op = ALU_SRL; c.src_a = SRCA_SHAMT; end
               FN_SRA:  begin c.alu_op = ALU_SRA; c.src_a = SRCA_SHAMT; end
               FN_SLLV: c.alu_op = ALU_SLL;
               FN_SRLV: c.alu_op = ALU_SRL;
               FN_SRAV: c.alu_op = ALU_SRA;
               FN_JR:   begin c.pc_src = PC_REG; c.reg_write = 1'b0; end
               FN_JALR: begin
                  c.pc_src = PC_REG;
                  c.src_a  = SRCA_PC;
                  c.src_b  = SRCB_EIGHT;
               end
               FN_ADDU: c.alu_op = ALU_ADD;
               FN_SUBU: c.alu_op = ALU_SUB;
               FN_AND:  c.alu_op = ALU_AND;
               FN_OR:   c.alu_op = ALU_OR;
               FN_XOR:  c.alu_op = ALU_XOR;
               FN_NOR:  c.alu_op = ALU_NOR;
               FN_SLT:  c.alu_op = ALU_SLT;
               FN_SLTU: c.alu_op = ALU_SLTU;
               default: c.reg_write = 1'b0;   // unsupported funct is a nop
            endcase
         end
         OP_REGIMM, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: c.pc_src = PC_BRANCH;
         OP_J: c.pc_src = PC_JUMP;
         OP_JAL: begin
            c.pc_src    = PC_JUMP;
            c.reg_dst   = DST_RA;
            c.reg_write = 1'b1;
            c.src_a     = SRCA_PC;
            c.src_b     = SRCB_EIGHT;
         end
         OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
            c.src_b     = SRCB_IMM;
            c.reg_write = 1'b1;
            case (op)
               OP_SLTI:  c.alu_op = ALU_SLT;
               OP_SLTIU: c.alu_op = ALU_SLTU;
               OP_ANDI:  begin c.alu_op = ALU_AND; c.imm_zero_ext = 1'b1; end
               OP_ORI:   begin c.alu_op = ALU_OR;  c.imm_zero_ext = 1'b1; end
               OP_XORI:  begin c.alu_op = ALU_XOR; c.imm_zero_ext = 1'b1; end
               OP_LUI:   c.alu_op = ALU_LUI;
               default:  c.alu_op = ALU_ADD;
            endcase
         end
         OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
            c.src_b       = SRCB_IMM;
            c.reg_write   = 1'b1;
            c.mem_read    = 1'b1;
            c.wb_sel      = WB_LOAD;
            c.load_signed = (op == OP_LB) || (op == OP_LH);
            if (op == OP_LB || op == OP_LBU) begin
               c.mem_size = SIZE_BYTE;
            end else if (op == OP_LH || op == OP_LHU) begin
               c.mem_size = SIZE_HALF;
            end
         end
         OP_SB, OP_SH, OP_SW: begin
            c.src_b     = SRCB_IMM;
            c.mem_write = 1'b1;
            if (op == OP_SB) begin
               c.mem_size = SIZE_BYTE;
            end else if (op == OP_SH) begin
               c.mem_size = SIZE_HALF;
            end
         end
         default: c.reg_write = 1'b0;
      endcase
      return c;
   endfunction

   function automatic reg_addr_t dest_of(input ex_ctrl_t c, input word_t instr);
      case (c.reg_dst)
         DST_RD:  return instr[15:11];
         DST_RA:  return 5'd31;
         default: return instr[20:16];
      endcase
   endfunction

   always_comb begin
      mw_ctrl = decode(mw_instr);
      mw_dest = dest_of(mw_ctrl, mw_instr);
      mw_fwd  = mw_ctrl.reg_write && !mw_ctrl.mem_read && (mw_dest != '0);   // alu results only
      ex_ctrl = decode(ex_instr);
      if (mw_fwd && (mw_dest == ex_instr[25:21]) && (ex_ctrl.src_a == SRCA_RS)) begin
         ex_ctrl.src_a = SRCA_FWD;
      end
      if (mw_fwd && (mw_dest == ex_instr[20:16]) && (ex_ctrl.src_b == SRCB_RT)) begin
         ex_ctrl.src_b = SRCB_FWD;
      end
   end

endmodule

`default_nettype wire

//--- mips_core.sv
`default_nettype none

module mips_core #(
   parameter mips_pkg::word_t RESET_PC     = '0,
   parameter mips_pkg::word_t COUNTER_BASE = 32'h8000_0010
) (
   input  logic                CLK,
   input  logic                arst_n,
   input  logic                stall,   // freezes every stage
   output mips_pkg::word_t     imem_addr,
   input  mips_pkg::word_t     imem_rdata,
   output mips_pkg::dmem_req_t dmem_req,
   input  mips_pkg::word_t     dmem_rdata
);
   import mips_pkg::*;

   ex_ctrl_t ex_ctrl;
   word_t    ex_instr;
   word_t    mw_instr;

   mips_control u_control (
      .ex_instr (ex_instr),
      .mw_instr (mw_instr),
      .ex_ctrl  (ex_ctrl)
   );

   mips_datapath #(
      .RESET_PC     (RESET_PC),
      .COUNTER_BASE (COUNTER_BASE)
   ) u_datapath (
      .CLK        (CLK),
      .arst_n     (arst_n),
      .stall      (stall),
      .ex_ctrl    (ex_ctrl),
      .ex_instr   (ex_instr),
      .mw_instr   (mw_instr),
      .imem_addr  (imem_addr),
      .imem_rdata (imem_rdata),
      .dmem_req   (dmem_req),
      .dmem_rdata (dmem_rdata)
   );

endmodule

`default_nettype wire

//--- mips_datapath.sv
`default_nettype none

module mips_datapath #(
   parameter mips_pkg::word_t RESET_PC     = '0,
   parameter mips_pkg::word_t COUNTER_BASE = 32'h8000_0010
) (
   input  logic                CLK,
   input  logic                arst_n,
   input  logic                stall,
   input  mips_pkg::ex_ctrl_t  ex_ctrl,
   output mips_pkg::word_t     ex_instr,
   output mips_pkg::word_t     mw_instr,
   output mips_pkg::word_t     imem_addr,
   input  mips_pkg::word_t     imem_rdata,
   output mips_pkg::dmem_req_t dmem_req,
   input  mips_pkg::word_t     dmem_rdata
);
   import mips_pkg::*;

   word_t     pc_if;
   word_t     pc_plus4;
   word_t     pc_next;
   logic      ex_valid;
   word_t     ex_pc;
   word_t     ex_pc4;
   reg_addr_t rs;
   reg_addr_t rt;
   reg_addr_t ex_dest;
   word_t     imm_ext;
   word_t     rd1;
   word_t     rd2;
   word_t     rs_val;
   word_t     rt_val;
   word_t     alu_a;
   word_t     alu_b;
   word_t     alu_result;
   word_t     br_target;
   word_t     j_target;
   logic      taken;
   logic      ex_cnt_hit;
   logic      ex_cnt_store;
   byte_en_t  st_byte_en;
   word_t     st_wdata;
   word_t     mw_alu;
   reg_addr_t mw_dest;
   logic      mw_reg_write;
   wb_sel_t   mw_wb_sel;
   mem_size_t mw_ld_size;
   logic      mw_ld_signed;
   logic      mw_cnt_hit;
   logic      mw_fwd_ok;
   word_t     ld_data;
   word_t     cnt_value;
   word_t     wb_data;

   assign imem_addr = pc_if;
   assign pc_plus4  = pc_if + 32'd4;
   assign ex_instr  = ex_valid ? imem_rdata : '0;   // bubble until the first fetch lands
   assign rs        = ex_instr[25:21];
   assign rt        = ex_instr[20:16];
   assign imm_ext   = ex_ctrl.imm_zero_ext ? {16'h0000, ex_instr[15:0]}
                                           : {{16{ex_instr[15]}}, ex_instr[15:0]};

   always_comb begin
      case (ex_ctrl.reg_dst)
         DST_RD:  ex_dest = ex_instr[15:11];
         DST_RA:  ex_dest = 5'd31;
         default: ex_dest = rt;
      endcase
   end

   mips_regfile u_regfile (
      .CLK    (CLK),
      .arst_n (arst_n),
      .we     (mw_reg_write & ~stall),
      .wa     (mw_dest),
      .ra1    (rs),
      .ra2    (rt),
      .wd     (wb_data),
      .rd1    (rd1),
      .rd2    (rd2)
   );

   // store data and register target bypass the alu muxes
   assign mw_fwd_ok = mw_reg_write && (mw_wb_sel == WB_ALU) && (mw_dest != '0);
   assign rs_val    = (mw_fwd_ok && (mw_dest == rs)) ? mw_alu : rd1;
   assign rt_val    = (mw_fwd_ok && (mw_dest == rt)) ? mw_alu : rd2;

   always_comb begin
      case (ex_ctrl.src_a)
         SRCA_PC:    alu_a = ex_pc;
         SRCA_FWD:   alu_a = mw_alu;
         SRCA_SHAMT: alu_a = {27'b0, ex_instr[10:6]};
         default:    alu_a = rd1;
      endcase
      case (ex_ctrl.src_b)
         SRCB_EIGHT: alu_b = 32'd8;
         SRCB_FWD:   alu_b = mw_alu;
         SRCB_IMM:   alu_b = imm_ext;
         default:    alu_b = rd2;
      endcase
   end

   mips_alu u_alu (
      .a      (alu_a),
      .b      (alu_b),
      .op     (ex_ctrl.alu_op),
      .result (alu_result)
   );

   mips_branch_cmp u_branch_cmp (
      .opcode (ex_instr[31:26]),
      .rt     (rt),
      .a      (alu_a),
      .b      (alu_b),
      .taken  (taken)
   );

   // targets relative to the delay slot
   assign br_target = ex_pc4 + {{14{ex_instr[15]}}, ex_instr[15:0], 2'b00};
   assign j_target  = {ex_pc4[31:28], ex_instr[25:0], 2'b00};

   always_comb begin
      case (ex_ctrl.pc_src)
         PC_BRANCH: pc_next = taken ? br_target : pc_plus4;
         PC_JUMP:   pc_next = j_target;
         PC_REG:    pc_next = rs_val;
         default:   pc_next = pc_plus4;
      endcase
   end

   assign ex_cnt_hit   = ex_ctrl.mem_read &&
                         ((alu_result == COUNTER_BASE) || (alu_result == COUNTER_BASE + 32'd4));
   assign ex_cnt_store = ex_ctrl.mem_write && (alu_result == COUNTER_BASE);

   mips_load_store_align u_align (
      .st_size    (ex_ctrl.mem_size),
      .st_en      (ex_ctrl.mem_write & ~stall & ~ex_cnt_store),
      .st_offset  (alu_result[1:0]),
      .st_data    (rt_val),
      .st_wdata   (st_wdata),
      .st_byte_en (st_byte_en),
      .ld_size    (mw_ld_size),
      .ld_signed  (mw_ld_signed),
      .ld_offset  (mw_alu[1:0]),
      .ld_raw     (dmem_rdata),
      .ld_data    (ld_data)
   );

   assign dmem_req.addr    = alu_result;
   assign dmem_req.wdata   = st_wdata;
   assign dmem_req.byte_en = st_byte_en;

   mips_perf_counters #(
      .COUNTER_BASE (COUNTER_BASE)
   ) u_counters (
      .CLK       (CLK),
      .arst_n    (arst_n),
      .stall     (stall),
      .retire    (mw_instr != '0),
      .clear     (ex_cnt_store),
      .sel_instr (mw_alu[2]),
      .value     (cnt_value)
   );

   always_comb begin
      case (mw_cnt_hit ? WB_COUNTER : mw_wb_sel)
         WB_LOAD:    wb_data = ld_data;
         WB_COUNTER: wb_data = cnt_value;
         default:    wb_data = mw_alu;
      endcase
   end

   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         pc_if        <= RESET_PC;
         ex_valid     <= 1'b0;
         mw_reg_write <= 1'b0;
         mw_instr     <= '0;
      end else if (!stall) begin
         pc_if        <= pc_next;
         ex_valid     <= 1'b1;
         mw_reg_write <= ex_ctrl.reg_write;
         mw_instr     <= ex_instr;
      end
   end

   always_ff @(posedge CLK) begin
      if (!stall) begin
         ex_pc        <= pc_if;
         ex_pc4       <= pc_plus4;
         mw_alu       <= alu_result;
         mw_dest      <= ex_dest;
         mw_wb_sel    <= ex_ctrl.wb_sel;
         mw_ld_size   <= ex_ctrl.mem_size;
         mw_ld_signed <= ex_ctrl.load_signed;
         mw_cnt_hit   <= ex_cnt_hit;
      end
   end

endmodule

`default_nettype wire

//--- mips_load_store_align.sv
`default_nettype none

module mips_load_store_align (
   input  mips_pkg::mem_size_t st_size,
   input  logic                st_en,
   input  logic [1:0]          st_offset,
   input  mips_pkg::word_t     st_data,
   output mips_pkg::word_t     st_wdata,
   output mips_pkg::byte_en_t  st_byte_en,
   input  mips_pkg::mem_size_t ld_size,
   input  logic                ld_signed,
   input  logic [1:0]          ld_offset,
   input  mips_pkg::word_t     ld_raw,
   output mips_pkg::word_t     ld_data
);
   import mips_pkg::*;

   logic [7:0]  ld_byte;
   logic [15:0] ld_half;

   // store side, data replicated into every lane
   always_comb begin
      case (st_size)
         SIZE_BYTE: begin
            st_wdata   = {4{st_data[7:0]}};
            st_byte_en = 4'b1000 >> st_offset;
         end
         SIZE_HALF: begin
            st_wdata   = {2{st_data[15:0]}};
            st_byte_en = st_offset[1] ? 4'b0011 : 4'b1100;
         end
         default: begin
            st_wdata   = st_data;
            st_byte_en = 4'b1111;
         end
      endcase
      if (!st_en) begin
         st_byte_en = '0;
      end
   end

   // load side, offset 0 is the most significant byte
   always_comb begin
      case (ld_offset)
         2'd0:    ld_byte = ld_raw[31:24];
         2'd1:    ld_byte = ld_raw[23:16];
         2'd2:    ld_byte = ld_raw[15:8];
         default: ld_byte = ld_raw[7:0];
      endcase
      ld_half = ld_offset[1] ? ld_raw[15:0] : ld_raw[31:16];
      case (ld_size)
         SIZE_BYTE: ld_data = {{24{ld_signed & ld_byte[7]}}, ld_byte};
         SIZE_HALF: ld_data = {{16{ld_signed & ld_half[15]}}, ld_half};
         default:   ld_data = ld_raw;
      endcase
   end

endmodule

`default_nettype wire

//--- mips_perf_counters.sv
`default_nettype none

module mips_perf_counters #(
   parameter mips_pkg::word_t COUNTER_BASE = 32'h8000_0010
) (
   input  logic            CLK,
   input  logic            arst_n,
   input  logic            stall,
   input  logic            retire,
   input  logic            clear,
   input  logic            sel_instr,
   output mips_pkg::word_t value
);
   import mips_pkg::*;

   word_t cycle_cnt;
   word_t instr_cnt;

   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         cycle_cnt <= '0;
         instr_cnt <= '0;
      end else if (!stall) begin
         if (clear) begin   // clear wins over counting
            cycle_cnt <= '0;
            instr_cnt <= '0;
         end else begin
            cycle_cnt <= cycle_cnt + 32'd1;
            if (retire) begin
               instr_cnt <= instr_cnt + 32'd1;
            end
         end
      end
   end

   // instr count sits at base+4, so bit 2 flips against the base
   assign value = (sel_instr ^ COUNTER_BASE[2]) ? instr_cnt : cycle_cnt;

endmodule

`default_nettype wire

//--- mips_pkg.sv
`default_nettype none

package mips_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_addr_t;
   typedef logic [5:0]  opcode_t;
   typedef logic [5:0]  funct_t;
   typedef logic [3:0]  byte_en_t;   // bit 3 is the byte at offset 0
   typedef logic [4:0]  shamt_t;

   typedef logic [3:0] alu_op_t;
   localparam alu_op_t ALU_ADD  = 4'd0;
   localparam alu_op_t ALU_SUB  = 4'd1;
   localparam alu_op_t ALU_AND  = 4'd2;
   localparam alu_op_t ALU_OR   = 4'd3;
   localparam alu_op_t ALU_XOR  = 4'd4;
   localparam alu_op_t ALU_NOR  = 4'd5;
   localparam alu_op_t ALU_SLT  = 4'd6;
   localparam alu_op_t ALU_SLTU = 4'd7;
   localparam alu_op_t ALU_SLL  = 4'd8;
   localparam alu_op_t ALU_SRL  = 4'd9;
   localparam alu_op_t ALU_SRA  = 4'd10;
   localparam alu_op_t ALU_LUI  = 4'd11;

   typedef logic [1:0] src_a_t;
   localparam src_a_t SRCA_RS    = 2'd0;
   localparam src_a_t SRCA_PC    = 2'd1;
   localparam src_a_t SRCA_FWD   = 2'd2;
   localparam src_a_t SRCA_SHAMT = 2'd3;

   typedef logic [1:0] src_b_t;
   localparam src_b_t SRCB_RT    = 2'd0;
   localparam src_b_t SRCB_EIGHT = 2'd1;   // return address offset
   localparam src_b_t SRCB_FWD   = 2'd2;
   localparam src_b_t SRCB_IMM   = 2'd3;

   typedef logic [1:0] reg_dst_t;
   localparam reg_dst_t DST_RT = 2'd0;
   localparam reg_dst_t DST_RD = 2'd1;
   localparam reg_dst_t DST_RA = 2'd2;

   typedef logic [1:0] wb_sel_t;
   localparam wb_sel_t WB_ALU     = 2'd0;
   localparam wb_sel_t WB_LOAD    = 2'd1;
   localparam wb_sel_t WB_COUNTER = 2'd2;

   typedef logic [1:0] pc_src_t;
   localparam pc_src_t PC_PLUS4  = 2'd0;
   localparam pc_src_t PC_BRANCH = 2'd1;
   localparam pc_src_t PC_JUMP   = 2'd2;
   localparam pc_src_t PC_REG    = 2'd3;

   typedef logic [1:0] mem_size_t;
   localparam mem_size_t SIZE_BYTE = 2'd0;
   localparam mem_size_t SIZE_HALF = 2'd1;
   localparam mem_size_t SIZE_WORD = 2'd2;

   localparam opcode_t OP_RTYPE  = 6'h00;
   localparam opcode_t OP_REGIMM = 6'h01;
   localparam opcode_t OP_J      = 6'h02;
   localparam opcode_t OP_JAL    = 6'h03;
   localparam opcode_t OP_BEQ    = 6'h04;
   localparam opcode_t OP_BNE    = 6'h05;
   localparam opcode_t OP_BLEZ   = 6'h06;
   localparam opcode_t OP_BGTZ   = 6'h07;
   localparam opcode_t OP_ADDIU  = 6'h09;
   localparam opcode_t OP_SLTI   = 6'h0a;
   localparam opcode_t OP_SLTIU  = 6'h0b;
   localparam opcode_t OP_ANDI   = 6'h0c;
   localparam opcode_t OP_ORI    = 6'h0d;
   localparam opcode_t OP_XORI   = 6'h0e;
   localparam opcode_t OP_LUI    = 6'h0f;
   localparam opcode_t OP_LB     = 6'h20;
   localparam opcode_t OP_LH     = 6'h21;
   localparam opcode_t OP_LW     = 6'h23;
   localparam opcode_t OP_LBU    = 6'h24;
   localparam opcode_t OP_LHU    = 6'h25;
   localparam opcode_t OP_SB     = 6'h28;
   localparam opcode_t OP_SH     = 6'h29;
   localparam opcode_t OP_SW     = 6'h2b;

   localparam funct_t FN_SLL  = 6'h00;
   localparam funct_t FN_SRL  = 6'h02;
   localparam funct_t FN_SRA  = 6'h03;
   localparam funct_t FN_SLLV = 6'h04;
   localparam funct_t FN_SRLV = 6'h06;
   localparam funct_t FN_SRAV = 6'h07;
   localparam funct_t FN_JR   = 6'h08;
   localparam funct_t FN_JALR = 6'h09;
   localparam funct_t FN_ADDU = 6'h21;
   localparam funct_t FN_SUBU = 6'h23;
   localparam funct_t FN_AND  = 6'h24;
   localparam funct_t FN_OR   = 6'h25;
   localparam funct_t FN_XOR  = 6'h26;
   localparam funct_t FN_NOR  = 6'h27;
   localparam funct_t FN_SLT  = 6'h2a;
   localparam funct_t FN_SLTU = 6'h2b;

   typedef struct packed {
      alu_op_t   alu_op;
      src_a_t    src_a;
      src_b_t    src_b;
      reg_dst_t  reg_dst;
      wb_sel_t   wb_sel;
      pc_src_t   pc_src;
      logic      reg_write;
      logic      mem_read;
      logic      mem_write;
      mem_size_t mem_size;
      logic      load_signed;
      logic      imm_zero_ext;
   } ex_ctrl_t;

   typedef struct packed {
      word_t    addr;
      word_t    wdata;
      byte_en_t byte_en;   // zero means no write
   } dmem_req_t;

endpackage

`default_nettype wire

//--- mips_regfile.sv
`default_nettype none

module mips_regfile (
   input  logic                CLK,
   input  logic                arst_n,
   input  logic                we,
   input  mips_pkg::reg_addr_t wa,
   input  mips_pkg::reg_addr_t ra1,
   input  mips_pkg::reg_addr_t ra2,
   input  mips_pkg::word_t     wd,
   output mips_pkg::word_t     rd1,
   output mips_pkg::word_t     rd2
);
   import mips_pkg::*;

   word_t regs [31:1];   // no storage for r0

   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we && (wa != '0)) begin
         regs[wa] <= wd;
      end
   end

   // reads see the old value during a same-cycle write
   assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
   assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

//--- sim.f
mips_pkg.sv
mips_alu.sv
mips_regfile.sv
mips_branch_cmp.sv
mips_load_store_align.sv
mips_perf_counters.sv
mips_control.sv
mips_datapath.sv
mips_core.sv
tb_clock_gen.sv
tb_mips_core.sv

//--- tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
   input  logic restart,   // rising edge reapplies reset
   output logic CLK,
   output logic arst_n
);

   initial begin
      CLK    = 1'b0;
      arst_n = 1'b0;
      repeat (2) @(posedge CLK);
      #10 arst_n = 1'b1;
   end

   always #50 CLK = ~CLK;   // period 100

   always @(posedge restart) begin
      arst_n = 1'b0;
      repeat (2) @(posedge CLK);
      #10 arst_n = 1'b1;
   end

endmodule

`default_nettype wire

//--- tb_mips_core.sv
`default_nettype none

module tb_mips_core;
   import mips_pkg::*;

   localparam word_t BASE     = 32'h0000_0100;   // store area pointer in r30
   localparam word_t START_PC = 32'h0000_0000;

   logic      CLK;
   logic      arst_n;
   logic      restart;
   logic      stall;
   logic      stall_on;
   logic      prog_ready;
   word_t     imem_addr;
   word_t     imem_rdata;
   dmem_req_t dmem_req;
   word_t     dmem_rdata;

   word_t imem [0:255];
   word_t dmem [0:1023];
   int    pc_idx;
   int    row;
   int    errors;

   string exp_name [$];
   word_t exp_addr [$];
   word_t exp_data [$];
   byte_en_t exp_be [$];
   logic  exp_min [$];   // value only has a lower bound

   tb_clock_gen u_clk (
      .restart (restart),
      .CLK     (CLK),
      .arst_n  (arst_n)
   );

   mips_core #(
      .RESET_PC     (START_PC),
      .COUNTER_BASE (32'h8000_0010)
   ) UUT (
      .CLK        (CLK),
      .arst_n     (arst_n),
      .stall      (stall),
      .imem_addr  (imem_addr),
      .imem_rdata (imem_rdata),
      .dmem_req   (dmem_req),
      .dmem_rdata (dmem_rdata)
   );

   function automatic word_t rtype(input funct_t fn, input int rd, input int rs, input int rt,
                                   input int sh);
      return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
   endfunction

   function automatic word_t itype(input opcode_t op, input int rt, input int rs, input int imm);
      return {op, rs[4:0], rt[4:0], imm[15:0]};
   endfunction

   function automatic word_t jtype(input opcode_t op, input int target);
      return {op, target[27:2]};
   endfunction

   task automatic emit(input word_t w);
      imem[pc_idx] = w;
      pc_idx++;
   endtask

   task automatic store_word(input int rt, input int off);
      emit(itype(OP_SW, rt, 30, off));
   endtask

   task automatic expect_store(input string nm, input int off, input word_t data,
                               input byte_en_t be, input logic at_least);
      exp_name.push_back(nm);
      exp_addr.push_back(BASE + off);
      exp_data.push_back(data);
      exp_be.push_back(be);
      exp_min.push_back(at_least);
   endtask

   task automatic alu_result(input word_t instr, input int rd, input int off, input word_t data,
                             input string nm);
      emit(instr);
      store_word(rd, off);
      expect_store(nm, off, data, 4'b1111, 1'b0);
   endtask

   // taken branch, target two words after the delay slot
   task automatic taken_block(input word_t br, input int d_off, input int t_off, input string nm);
      emit(br);
      store_word(1, d_off);
      store_word(1, 12'h3f0);   // not-taken path, must not show up
      store_word(1, t_off);
      expect_store({nm, " delay slot"}, d_off, 32'd5, 4'b1111, 1'b0);
      expect_store({nm, " target"}, t_off, 32'd5, 4'b1111, 1'b0);
   endtask

   task automatic load_block(input opcode_t op, input int ld_off, input int st_off,
                             input word_t data, input string nm);
      emit(itype(op, 25, 30, ld_off));
      emit(itype(OP_ADDIU, 26, 26, 1));   // independent slot after the load
      store_word(25, st_off);
      expect_store(nm, st_off, data, 4'b1111, 1'b0);
   endtask

   task automatic compare_value(input string nm, input word_t expected, input word_t actual,
                                input logic at_least);
      if (at_least ? (actual < expected) : (actual !== expected)) begin
         errors++;
         $display("** Error %s: expected %s%h, actual %h", nm, at_least ? ">= " : "",
                  expected, actual);
      end
   endtask

   task automatic fill_dmem;
      for (int i = 0; i < 1024; i++) begin
         dmem[i] = (i * 32'h9e37_79b1) ^ 32'ha5a5_a5a5;
      end
   endtask

   task automatic build_program;
      int       p;
      byte_en_t sb_be [0:3] = '{4'b1000, 4'b0100, 4'b0010, 4'b0001};
      pc_idx = 0;
      for (int i = 0; i < 256; i++) begin
         imem[i] = '0;
      end
      emit(itype(OP_ORI, 30, 0, BASE));
      emit(itype(OP_ADDIU, 1, 0, 5));
      emit(itype(OP_ADDIU, 2, 1, -7));   // r2 = -2 via forwarding
      alu_result(rtype(FN_ADDU, 3, 1, 2, 0), 3, 0, 32'd3, "addu");
      alu_result(rtype(FN_SUBU, 4, 1, 2, 0), 4, 4, 32'd7, "subu");
      alu_result(rtype(FN_AND, 5, 1, 2, 0), 5, 8, 32'd4, "and");
      alu_result(rtype(FN_OR, 6, 1, 2, 0), 6, 12, 32'hffff_ffff, "or");
      alu_result(rtype(FN_XOR, 7, 1, 2, 0), 7, 16, 32'hffff_fffb, "xor");
      alu_result(rtype(FN_NOR, 8, 1, 0, 0), 8, 20, 32'hffff_fffa, "nor");
      alu_result(rtype(FN_SLT, 9, 2, 1, 0), 9, 24, 32'd1, "slt");
      alu_result(rtype(FN_SLTU, 10, 1, 2, 0), 10, 28, 32'd1, "sltu");
      alu_result(rtype(FN_SLL, 11, 0, 1, 4), 11, 32, 32'h50, "sll");
      alu_result(rtype(FN_SRA, 12, 0, 2, 1), 12, 36, 32'hffff_ffff, "sra");
      alu_result(rtype(FN_SRL, 13, 0, 2, 28), 13, 40, 32'hf, "srl");
      emit(itype(OP_LUI, 14, 0, 16'h1234));
      alu_result(itype(OP_ORI, 14, 14, 16'h5678), 14, 44, 32'h1234_5678, "lui ori");
      alu_result(itype(OP_ANDI, 15, 14, 16'hff00), 15, 48, 32'h5600, "andi");
      alu_result(itype(OP_XORI, 16, 14, 16'hffff), 16, 52, 32'h1234_a987, "xori");
      alu_result(itype(OP_SLTI, 17, 2, -1), 17, 56, 32'd1, "slti");
      alu_result(itype(OP_SLTIU, 18, 1, -1), 18, 60, 32'd1, "sltiu");
      emit(itype(OP_ADDIU, 19, 0, 3));
      alu_result(rtype(FN_SLLV, 20, 19, 1, 0), 20, 64, 32'h28, "sllv");
      alu_result(rtype(FN_SRLV, 21, 19, 2, 0), 21, 68, 32'h1fff_ffff, "srlv");
      // branches and jumps
      taken_block(itype(OP_BEQ, 1, 1, 2), 72, 76, "beq");
      taken_block(itype(OP_BNE, 2, 1, 2), 80, 84, "bne");
      taken_block(itype(OP_BLEZ, 0, 2, 2), 88, 92, "blez");
      taken_block(itype(OP_BGTZ, 0, 1, 2), 96, 100, "bgtz");
      taken_block(itype(OP_REGIMM, 0, 2, 2), 104, 108, "bltz");
      taken_block(itype(OP_REGIMM, 1, 1, 2), 112, 116, "bgez");
      taken_block(jtype(OP_J, pc_idx * 4 + 12), 120, 124, "j");
      p = pc_idx * 4;
      emit(jtype(OP_JAL, p + 12));
      store_word(1, 128);
      store_word(1, 12'h3f0);
      store_word(31, 132);
      expect_store("jal delay slot", 128, 32'd5, 4'b1111, 1'b0);
      expect_store("jal link", 132, p + 8, 4'b1111, 1'b0);
      p = pc_idx * 4;
      emit(itype(OP_ORI, 23, 0, p + 16));
      emit(rtype(FN_JR, 0, 23, 0, 0));
      store_word(1, 136);
      store_word(1, 12'h3f0);
      store_word(1, 140);
      expect_store("jr delay slot", 136, 32'd5, 4'b1111, 1'b0);
      expect_store("jr target", 140, 32'd5, 4'b1111, 1'b0);
      emit(itype(OP_BNE, 1, 1, 2));   // never taken
      store_word(1, 144);
      store_word(1, 148);
      store_word(1, 152);
      expect_store("bne not taken delay", 144, 32'd5, 4'b1111, 1'b0);
      expect_store("bne fall through", 148, 32'd5, 4'b1111, 1'b0);
      expect_store("bne after", 152, 32'd5, 4'b1111, 1'b0);
      // sub-word stores of r14
      for (int k = 0; k < 4; k++) begin
         emit(itype(OP_SB, 14, 30, 156 + k));
         expect_store($sformatf("sb offset %0d", k), 156 + k, 32'h7878_7878,
                      sb_be[k], 1'b0);
      end
      emit(itype(OP_SH, 14, 30, 160));
      emit(itype(OP_SH, 14, 30, 162));
      expect_store("sh offset 0", 160, 32'h5678_5678, 4'b1100, 1'b0);
      expect_store("sh offset 2", 162, 32'h5678_5678, 4'b0011, 1'b0);
      // loads from a known word
      emit(itype(OP_LUI, 24, 0, 16'h80f1));
      alu_result(itype(OP_ORI, 24, 24, 16'h7f02), 24, 164, 32'h80f1_7f02, "load source");
      load_block(OP_LB, 164, 168, 32'hffff_ff80, "lb 0");
      load_block(OP_LBU, 165, 172, 32'h0000_00f1, "lbu 1");
      load_block(OP_LB, 166, 176, 32'h0000_007f, "lb 2");
      load_block(OP_LBU, 167, 180, 32'h0000_0002, "lbu 3");
      load_block(OP_LB, 165, 184, 32'hffff_fff1, "lb 1");
      load_block(OP_LH, 164, 188, 32'hffff_80f1, "lh 0");
      load_block(OP_LHU, 164, 192, 32'h0000_80f1, "lhu 0");
      load_block(OP_LH, 166, 196, 32'h0000_7f02, "lh 2");
      load_block(OP_LW, 164, 200, 32'h80f1_7f02, "lw");
      // counters, clear then three instructions then the reads
      emit(itype(OP_LUI, 27, 0, 16'h8000));
      emit(itype(OP_ORI, 27, 27, 16'h0010));
      emit(itype(OP_SW, 0, 27, 0));
      emit(itype(OP_ADDIU, 26, 26, 1));
      emit(itype(OP_ADDIU, 26, 26, 1));
      emit(itype(OP_ADDIU, 26, 26, 1));
      emit(itype(OP_LW, 28, 27, 4));
      emit(itype(OP_LW, 29, 27, 0));
      emit(itype(OP_ADDIU, 26, 26, 1));
      store_word(28, 204);
      store_word(29, 208);
      expect_store("instr count", 204, 32'd4, 4'b1111, 1'b0);
      expect_store("cycle count", 208, 32'd5, 4'b1111, 1'b1);
      emit(jtype(OP_J, pc_idx * 4));   // park here
      emit(32'h0);
   endtask

   // behavioral memories, read data holds during stall
   always @(posedge CLK) begin
      if (!stall) begin
         imem_rdata <= imem[imem_addr[9:2]];
         dmem_rdata <= dmem[dmem_req.addr[11:2]];
         if (dmem_req.byte_en[3]) dmem[dmem_req.addr[11:2]][31:24] <= dmem_req.wdata[31:24];
         if (dmem_req.byte_en[2]) dmem[dmem_req.addr[11:2]][23:16] <= dmem_req.wdata[23:16];
         if (dmem_req.byte_en[1]) dmem[dmem_req.addr[11:2]][15:8]  <= dmem_req.wdata[15:8];
         if (dmem_req.byte_en[0]) dmem[dmem_req.addr[11:2]][7:0]   <= dmem_req.wdata[7:0];
      end
   end

   // store monitor against the expected table
   always @(posedge CLK) begin
      if (arst_n && (dmem_req.byte_en != '0)) begin
         if (row < exp_name.size()) begin
            compare_value({exp_name[row], " addr"}, exp_addr[row], dmem_req.addr, 1'b0);
            compare_value({exp_name[row], " data"}, exp_data[row], dmem_req.wdata,
                          exp_min[row]);
            compare_value({exp_name[row], " byte_en"}, exp_be[row], dmem_req.byte_en, 1'b0);
            row++;
         end else begin
            errors++;
            $display("unexpected store to %h after the last expected store", dmem_req.addr);
         end
      end
   end

   initial begin
      void'($urandom(32'hd8c83201));
      forever begin
         @(posedge CLK);
         #10;
         stall = stall_on ? (($urandom % 4) == 0) : 1'b0;
      end
   end

   initial begin
      longint limit;
      wait (prog_ready);
      limit = 2 * (pc_idx * 4 + 200) * 100;
      #(limit);
      $display("timeout: %0d of %0d expected stores seen", row, exp_name.size());
      $display("TESTS FAILED");
      $finish;
   end

   initial begin
      stall      = 1'b0;
      stall_on   = 1'b0;
      restart    = 1'b0;
      prog_ready = 1'b0;
      imem_rdata = '0;
      dmem_rdata = '0;
      row        = 0;
      errors     = 0;
      build_program();
      fill_dmem();
      prog_ready = 1'b1;
      wait (arst_n);
      compare_value("reset pc", START_PC, imem_addr, 1'b0);
      wait (row == exp_name.size());
      // second pass under random stall
      @(posedge CLK);
      #10;
      fill_dmem();
      row     = 0;
      restart = 1'b1;
      wait (!arst_n);
      restart = 1'b0;
      wait (arst_n);
      compare_value("reset pc again", START_PC, imem_addr, 1'b0);
      stall_on = 1'b1;
      wait (row == exp_name.size());
      stall_on = 1'b0;
      repeat (10) @(posedge CLK);
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
